/* common/spi_cfg_pkg.sv */
package spi_cfg_pkg;

    // ----------------------------------------------------------
    // Frame
    // ----------------------------------------------------------

    // Bits per transfer, MSB first
    localparam int FRAME_BITS = 8;
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS);  // Bit counter width

    // ----------------------------------------------------------
    // Serial clock divider
    // ----------------------------------------------------------

    // pllClk_i cycles per master tick
    // One tick is half an sclk period, so sclk = pllClk_i / 8
    localparam int TICK_DIV   = 4;
    localparam int TICK_CNT_W = $clog2(TICK_DIV);    // 2 bits

    // ----------------------------------------------------------
    // Transfer timing
    // ----------------------------------------------------------

    // Setup tick, two ticks per bit, hold tick
    localparam int XFER_TICKS = 1 + 2 * FRAME_BITS + 1;

    // Start edge to master done pulse, in pllClk_i cycles (72)
    localparam int XFER_CYCLES = XFER_TICKS * TICK_DIV;

endpackage

/* common/spi_state_pkg.sv */
package spi_state_pkg;

    // ----------------------------------------------------------
    // Master controller
    // ----------------------------------------------------------

    typedef enum logic [1:0] {
        MST_IDLE  = 2'd0,  // Waiting for start, ready high
        MST_SETUP = 2'd1,  // One tick before ss_n falls
        MST_SHIFT = 2'd2,  // Toggling sclk, FRAME_BITS periods
        MST_HOLD  = 2'd3   // Hold tick, then ss_n rises
    } master_state_t;

    // ----------------------------------------------------------
    // Slave controller
    // ----------------------------------------------------------

    typedef enum logic [1:0] {
        SLV_IDLE   = 2'd0,  // Deselected, miso held at 0
        SLV_ACTIVE = 2'd1,  // Selected, shifting bits
        SLV_DONE   = 2'd2   // Full frame seen, wait for ss_n high
    } slave_state_t;

endpackage

/* spi_master/spi_master.sv */
`timescale 1ns/1ps

// SPI mode 0 master, one frame per start strobe
module spi_master
    import spi_cfg_pkg::*, spi_state_pkg::*;
(
    input  logic                  pllClk_i,   // System clock
    input  logic                  rst_i,      // Sync reset, active high
    input  logic                  start_i,    // One-cycle start strobe
    input  logic [FRAME_BITS-1:0] tx_data_i,  // Byte to slave
    input  logic                  miso_i,     // Serial data from slave
    output logic                  sclk_o,     // Serial clock, idles low
    output logic                  ss_n_o,     // Chip select, active low
    output logic                  mosi_o,     // Serial data to slave
    output logic [FRAME_BITS-1:0] rx_data_o,  // Byte from slave
    output logic                  done_o,     // One-cycle done pulse
    output logic                  ready_o     // High while idle
);

    master_state_t         state;
    logic [TICK_CNT_W-1:0] tick_cnt;   // Divider count
    logic                  tick;       // Half sclk period elapsed
    logic                  start_ok;   // Start accepted this cycle
    logic [BIT_CNT_W-1:0]  bit_cnt;    // Bits completed in frame
    logic                  last_bit;
    logic [FRAME_BITS-1:0] tx_shift;   // MOSI side
    logic [FRAME_BITS-1:0] rx_shift;   // MISO side

    // Start is only taken while idle, otherwise dropped
    assign start_ok = start_i && (state == MST_IDLE);
    assign last_bit = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

    // ----------------------------------------------------------
    // Divider tick
    // ----------------------------------------------------------

    // Tick fires on the last count of each divider period
    assign tick = (state != MST_IDLE) && (tick_cnt == TICK_CNT_W'(TICK_DIV - 1));

    always_ff @(posedge pllClk_i) begin
        if (rst_i) begin
            tick_cnt <= '0;
        end else if (state == MST_IDLE || tick) begin
            tick_cnt <= '0;               // Held while idle, so start aligns ticks
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Controller
    // ----------------------------------------------------------

    always_ff @(posedge pllClk_i) begin
        if (rst_i) begin
            state     <= MST_IDLE;
            sclk_o    <= 1'b0;
            ss_n_o    <= 1'b1;
            bit_cnt   <= '0;
            done_o    <= 1'b0;
            rx_data_o <= '0;
        end else begin
            done_o <= 1'b0;                   // Pulse by default
            case (state)
                MST_IDLE: begin
                    if (start_ok) begin
                        state <= MST_SETUP;
                    end
                end

                MST_SETUP: begin
                    // Select the slave, MSB already on mosi
                    if (tick) begin
                        ss_n_o  <= 1'b0;
                        bit_cnt <= '0;
                        state   <= MST_SHIFT;
                    end
                end

                MST_SHIFT: begin
                    if (tick) begin
                        sclk_o <= ~sclk_o;
                        if (sclk_o) begin         // Falling edge closes a bit
                            bit_cnt <= bit_cnt + 1'b1;
                            if (last_bit) begin
                                state <= MST_HOLD;
                            end
                        end
                    end
                end

                MST_HOLD: begin
                    if (done_o) begin
                        state <= MST_IDLE;        // Ready one cycle after done
                    end else if (tick) begin
                        ss_n_o    <= 1'b1;        // Deselect after hold tick
                        done_o    <= 1'b1;
                        rx_data_o <= rx_shift;    // Held until next done
                    end
                end

                default: begin
                    state <= MST_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Shift registers
    // ----------------------------------------------------------

    always_ff @(posedge pllClk_i) begin
        if (start_ok) begin
            tx_shift <= tx_data_i;            // Captured, input free to change
        end else if (state == MST_SHIFT && tick) begin
            if (sclk_o) begin
                // Fall: next MOSI bit
                tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
            end else begin
                // Rise: sample MISO
                rx_shift <= {rx_shift[FRAME_BITS-2:0], miso_i};
            end
        end
    end

    // ----------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------

    assign mosi_o  = ~ss_n_o & tx_shift[FRAME_BITS-1];  // Low while deselected
    assign ready_o = (state == MST_IDLE);

endmodule

/* spi_slave/spi_slave.sv */
`timescale 1ns/1ps

// SPI mode 0 slave, edges found by oversampling on pllClk_i
module spi_slave
    import spi_cfg_pkg::*, spi_state_pkg::*;
(
    input  logic                  pllClk_i,   // System clock
    input  logic                  rst_i,      // Sync reset, active high
    input  logic                  sclk_i,     // Serial clock from master
    input  logic                  ss_n_i,     // Chip select, active low
    input  logic                  mosi_i,     // Serial data from master
    input  logic [FRAME_BITS-1:0] tx_data_i,  // Byte to master
    output logic                  miso_o,     // Serial data to master
    output logic [FRAME_BITS-1:0] rx_data_o,  // Byte from master
    output logic                  done_o      // One-cycle done pulse
);

    slave_state_t          state;
    logic                  sclk_q;     // sclk one cycle back
    logic                  ss_n_q;     // ss_n one cycle back
    logic                  sclk_rise;
    logic                  sclk_fall;
    logic                  ss_fall;    // Frame start
    logic                  ss_rise;    // Frame end or abort
    logic [BIT_CNT_W-1:0]  bit_cnt;    // Bits sampled so far
    logic                  last_bit;
    logic [FRAME_BITS-1:0] tx_shift;   // MISO side
    logic [FRAME_BITS-1:0] rx_shift;   // MOSI side

    // ----------------------------------------------------------
    // Edge detection
    // ----------------------------------------------------------

    // Registered copies give the one-cycle lag behind the master
    always_ff @(posedge pllClk_i) begin
        if (rst_i) begin
            sclk_q <= 1'b0;                   // Bus idle levels
            ss_n_q <= 1'b1;
        end else begin
            sclk_q <= sclk_i;
            ss_n_q <= ss_n_i;
        end
    end

    assign sclk_rise = sclk_i & ~sclk_q;
    assign sclk_fall = ~sclk_i & sclk_q;
    assign ss_fall   = ~ss_n_i & ss_n_q;
    assign ss_rise   = ss_n_i & ~ss_n_q;

    assign last_bit = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

    // ----------------------------------------------------------
    // Controller
    // ----------------------------------------------------------

    always_ff @(posedge pllClk_i) begin
        if (rst_i) begin
            state     <= SLV_IDLE;
            bit_cnt   <= '0;
            rx_data_o <= '0;
        end else begin
            case (state)
                SLV_IDLE: begin
                    if (ss_fall) begin
                        bit_cnt <= '0;
                        state   <= SLV_ACTIVE;
                    end
                end

                SLV_ACTIVE: begin
                    if (ss_rise) begin
                        state <= SLV_IDLE;        // Short frame dropped, no done
                    end else if (sclk_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            // Final bit goes straight into the output
                            rx_data_o <= {rx_shift[FRAME_BITS-2:0], mosi_i};
                            state     <= SLV_DONE;
                        end
                    end
                end

                SLV_DONE: begin
                    if (ss_n_i) begin
                        state <= SLV_IDLE;
                    end
                end

                default: begin
                    state <= SLV_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Shift registers
    // ----------------------------------------------------------

    always_ff @(posedge pllClk_i) begin
        if (state == SLV_IDLE && ss_fall) begin
            tx_shift <= tx_data_i;            // MSB valid before first rise
        end else if (state == SLV_ACTIVE && sclk_fall) begin
            tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
        end

        if (state == SLV_ACTIVE && sclk_rise) begin
            rx_shift <= {rx_shift[FRAME_BITS-2:0], mosi_i};
        end
    end

    // ----------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------

    // MISO held low unless a frame is open
    assign miso_o = (state != SLV_IDLE) & tx_shift[FRAME_BITS-1];

    // Single cycle, as the controller leaves DONE on the same level
    assign done_o = (state == SLV_DONE) & ss_n_i;

endmodule

/* source/spi_loopback_top.sv */
`timescale 1ns/1ps

// SPI master and slave wired back to back on one clock
module spi_loopback_top
    import spi_cfg_pkg::*;
(
    input  logic                  pllClk_i,          // System clock
    input  logic                  rst_i,             // Sync reset, active high
    input  logic                  start_i,           // Start strobe to master
    input  logic [FRAME_BITS-1:0] master_tx_data_i,  // Master to slave byte
    input  logic [FRAME_BITS-1:0] slave_tx_data_i,   // Slave to master byte
    output logic                  ready_o,           // Master idle
    output logic [FRAME_BITS-1:0] master_rx_data_o,  // Byte seen by master
    output logic                  master_done_o,
    output logic [FRAME_BITS-1:0] slave_rx_data_o,   // Byte seen by slave
    output logic                  slave_done_o
);

    // ----------------------------------------------------------
    // SPI bus
    // ----------------------------------------------------------

    logic spi_sclk;    // Idles low
    logic spi_ss_n;    // Idles high
    logic spi_mosi;
    logic spi_miso;    // 0 while deselected

    // Master
    spi_master i_master (
        .pllClk_i  (pllClk_i),
        .rst_i     (rst_i),
        .start_i   (start_i),
        .tx_data_i (master_tx_data_i),
        .miso_i    (spi_miso),
        .sclk_o    (spi_sclk),
        .ss_n_o    (spi_ss_n),
        .mosi_o    (spi_mosi),
        .rx_data_o (master_rx_data_o),
        .done_o    (master_done_o),
        .ready_o   (ready_o)
    );

    // Slave, finds bus edges on pllClk_i
    spi_slave i_slave (
        .pllClk_i  (pllClk_i),
        .rst_i     (rst_i),
        .sclk_i    (spi_sclk),
        .ss_n_i    (spi_ss_n),
        .mosi_i    (spi_mosi),
        .tx_data_i (slave_tx_data_i),
        .miso_o    (spi_miso),
        .rx_data_o (slave_rx_data_o),
        .done_o    (slave_done_o)
    );

endmodule

/* dv/spi_loopback_asserts.sv */
`timescale 1ns/1ps

// Protocol checks on the SPI bus and the master handshake
module spi_loopback_asserts
    import spi_state_pkg::*;
(
    input logic          pllClk_i,       // System clock
    input logic          rst_i,          // Sync reset, active high
    input logic          spi_sclk_i,     // Bus serial clock
    input logic          spi_ss_n_i,     // Bus chip select
    input logic          ready_i,        // Master idle flag
    input logic          master_done_i,  // Master done pulse
    input master_state_t mst_state_i     // Master controller state
);

    // ----------------------------------------------------------
    // Bus
    // ----------------------------------------------------------

    // Selected from first shift until the done cycle
    ss_low_in_frame: assert property (
        @(posedge pllClk_i) disable iff (rst_i)
        ((mst_state_i == MST_SHIFT) || (mst_state_i == MST_HOLD && !master_done_i))
            |-> !spi_ss_n_i
    ) else $error("ss_n went high inside a frame");

    // Any sclk edge lands while selected
    sclk_edge_selected: assert property (
        @(posedge pllClk_i) disable iff (rst_i)
        (spi_sclk_i != $past(spi_sclk_i)) |-> !spi_ss_n_i
    ) else $error("sclk toggled while deselected");

    sclk_idle_low: assert property (
        @(posedge pllClk_i) disable iff (rst_i)
        spi_ss_n_i |-> !spi_sclk_i
    ) else $error("sclk high while deselected");

    // ----------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------

    // Busy from the start edge until the done pulse
    ready_low_busy: assert property (
        @(posedge pllClk_i) disable iff (rst_i)
        (!ready_i && !master_done_i) |=> !ready_i
    ) else $error("ready rose before master done");

    done_one_cycle: assert property (
        @(posedge pllClk_i) disable iff (rst_i)
        master_done_i |=> !master_done_i
    ) else $error("master done longer than one cycle");

endmodule

// Attached to the loopback top, state taken from the master instance
bind spi_loopback_top spi_loopback_asserts i_asserts (
    .pllClk_i      (pllClk_i),
    .rst_i         (rst_i),
    .spi_sclk_i    (spi_sclk),
    .spi_ss_n_i    (spi_ss_n),
    .ready_i       (ready_o),
    .master_done_i (master_done_o),
    .mst_state_i   (i_master.state)
);

/* dv/spi_loopback_tb.sv */
`timescale 1ns/1ps

module spi_loopback_tb
    import spi_cfg_pkg::*;
();

    localparam int CLK_PERIOD      = 10;               // ns
    localparam int POKE_CYCLE      = 10;               // Inputs disturbed mid-frame here
    localparam int XFER_MARGIN     = 16;               // Slack per transfer, cycles
    localparam int XFERS_RUN       = 1 + 2 + 2 + 20;   // Idle window counted as one
    localparam int WATCHDOG_CYCLES = XFERS_RUN * (XFER_CYCLES + XFER_MARGIN) + 100;

    logic                  pllClk_i;
    logic                  rst_i;
    logic                  start_i;
    logic [FRAME_BITS-1:0] master_tx_data_i;
    logic [FRAME_BITS-1:0] slave_tx_data_i;
    logic                  ready_o;
    logic [FRAME_BITS-1:0] master_rx_data_o;
    logic                  master_done_o;
    logic [FRAME_BITS-1:0] slave_rx_data_o;
    logic                  slave_done_o;

    spi_loopback_top i_dut (
        .pllClk_i         (pllClk_i),
        .rst_i            (rst_i),
        .start_i          (start_i),
        .master_tx_data_i (master_tx_data_i),
        .slave_tx_data_i  (slave_tx_data_i),
        .ready_o          (ready_o),
        .master_rx_data_o (master_rx_data_o),
        .master_done_o    (master_done_o),
        .slave_rx_data_o  (slave_rx_data_o),
        .slave_done_o     (slave_done_o)
    );

    // ----------------------------------------------------------
    // Clock and watchdog
    // ----------------------------------------------------------

    initial begin
        pllClk_i = 1'b0;
        forever #(CLK_PERIOD / 2) pllClk_i = ~pllClk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a test stalled", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "Watchdog timeout");
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // One frame from start to ready, all timing and data checked
    task automatic run_transfer(input string test_name, input logic [FRAME_BITS-1:0] mst_byte,
                                input logic [FRAME_BITS-1:0] slv_byte, input logic extra_start);
        int cycles;
        int latency;
        int mst_dones;
        int slv_dones;

        cycles    = 0;
        latency   = 0;
        mst_dones = 0;
        slv_dones = 0;
        if (!ready_o) begin
            stop_run($sformatf("%s: master not ready before start", test_name));
        end
        start_i          = 1'b1;
        master_tx_data_i = mst_byte;
        slave_tx_data_i  = slv_byte;
        @(posedge pllClk_i);                  // Start edge
        #1;
        start_i = 1'b0;
        check_value({test_name, " ready_low"}, 32'd0, 32'(ready_o));

        do begin
            @(posedge pllClk_i);
            #1;
            cycles++;
            start_i = extra_start && (cycles == POKE_CYCLE);  // Must be dropped
            if (cycles == POKE_CYCLE) begin
                master_tx_data_i = ~mst_byte;   // Frame already captured
                slave_tx_data_i  = ~slv_byte;
            end
            if (master_done_o) begin
                mst_dones++;
                latency = cycles;
            end
            if (slave_done_o) begin
                slv_dones++;
            end
            if (cycles > XFER_CYCLES + XFER_MARGIN) begin
                stop_run($sformatf("%s: no done and ready after %0d cycles", test_name, cycles));
            end
        end while (!(ready_o && mst_dones > 0));

        check_value({test_name, " latency"}, 32'(XFER_CYCLES), 32'(latency));
        check_value({test_name, " master_dones"}, 32'd1, 32'(mst_dones));
        check_value({test_name, " slave_dones"}, 32'd1, 32'(slv_dones));   // Before ready
        check_value({test_name, " master_rx"}, 32'(slv_byte), 32'(master_rx_data_o));
        check_value({test_name, " slave_rx"}, 32'(mst_byte), 32'(slave_rx_data_o));
    endtask

    // ----------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------

    task automatic test_reset_values();
        check_value("reset ready", 32'd1, 32'(ready_o));
        check_value("reset master_done", 32'd0, 32'(master_done_o));
        check_value("reset slave_done", 32'd0, 32'(slave_done_o));
        check_value("reset master_rx", 32'd0, 32'(master_rx_data_o));
        check_value("reset slave_rx", 32'd0, 32'(slave_rx_data_o));
    endtask

    task automatic test_fixed_pattern();
        run_transfer("fixed_pattern", 8'hA5, 8'h3C, 1'b0);
    endtask

    // Extreme bytes, slave done once per frame
    task automatic test_slave_done();
        run_transfer("slave_done ones", 8'hFF, 8'h00, 1'b0);
        run_transfer("slave_done zeros", 8'h00, 8'hFF, 1'b0);
    endtask

    task automatic test_ignored_start();
        run_transfer("ignored_start", 8'hD2, 8'h4B, 1'b1);
        // Quiet window, a second frame would show here
        repeat (XFER_CYCLES) begin
            @(posedge pllClk_i);
            #1;
            check_value("ignored_start idle_done", 32'd0, 32'(master_done_o));
            check_value("ignored_start idle_ready", 32'd1, 32'(ready_o));
        end
        check_value("ignored_start held_master_rx", 32'h4B, 32'(master_rx_data_o));
        check_value("ignored_start held_slave_rx", 32'hD2, 32'(slave_rx_data_o));
    endtask

    task automatic test_back_to_back();
        logic [FRAME_BITS-1:0] mst_byte;
        logic [FRAME_BITS-1:0] slv_byte;

        for (int i = 0; i < 20; i++) begin
            mst_byte = FRAME_BITS'($urandom);
            slv_byte = FRAME_BITS'($urandom);
            run_transfer($sformatf("back_to_back[%0d]", i), mst_byte, slv_byte, 1'b0);
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------

    initial begin
        void'($urandom(32'hae89));
        rst_i            = 1'b1;
        start_i          = 1'b0;
        master_tx_data_i = '0;
        slave_tx_data_i  = '0;
        repeat (4) @(posedge pllClk_i);       // Reset for 4 cycles
        #1;
        rst_i = 1'b0;

        test_reset_values();
        test_fixed_pattern();
        test_slave_done();
        test_ignored_start();
        test_back_to_back();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* spi_loopback.f */
common/spi_cfg_pkg.sv
common/spi_state_pkg.sv
spi_master/spi_master.sv
spi_slave/spi_slave.sv
source/spi_loopback_top.sv
dv/spi_loopback_asserts.sv
dv/spi_loopback_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SPI loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module spi_loopback_tb \
    -f spi_loopback.f \
    --Mdir obj_dir \
    -o spi_loopback_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/spi_loopback_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit $sim_status
fi

exit 0
